//--- ioBridge_macros.svh
`ifndef IOB_MACROS_SVH
`define IOB_MACROS_SVH

// Strobe cycles before a silent device is treated as a bus error
`define IOB_TIMEOUT 64

// Shortest strobe the slow peripherals accept
`define IOB_MIN_STROBE 4

// I/O window on the FSB, in word addresses
`define IOB_IO_BASE 23'h780000
`define IOB_IO_WORDS 256

`endif

//--- ioBridgePkg.sv
package ioBridgePkg;

	// FSB word address, bits A23..A1
	typedef logic [22:0] fsbAddrT;

	// One I/O bus data word
	typedef logic [15:0] ioDataT;

	// Byte lanes, bit 1 upper (UDS) and bit 0 lower (LDS)
	typedef logic [1:0] byteEnT;

	// Slave transfer states
	// Encoding kept equal to the old TS numbering
	typedef enum logic [1:0] {
		tsIdle     = 2'd0, // Waiting for level 1 or an FSB request
		tsWaitDone = 2'd1, // Master owns the cycle, wait for ioAct low
		tsWaitAct  = 2'd2, // Request up, wait for ioAct
		tsStart    = 2'd3  // Strobes picked, level 0 about to close
	} xferStateT;

	// Master states
	typedef enum logic [1:0] {
		mIdle,   // No cycle, watching the request levels
		mStrobe, // Setup beat, then strobe held on the I/O bus
		mFinish, // Strobe removed
		mDone    // ioDone pulse
	} iobStateT;

endpackage

//--- iobSlave.sv
`timescale 1ns/1ps

module iobSlave import ioBridgePkg::*; (
	input  logic CLK,
	input  logic reset,
	input  logic nWE,
	input  logic nAS,
	input  logic nLDS,
	input  logic nUDS,
	input  logic bact,      // Address strobe cycle active
	input  logic ioCs,      // I/O space selected
	input  logic ioPwCs,    // Posted-write region selected
	input  logic overlay,   // Boot ROM overlay
	output logic ioReady,
	output logic ioPwReady,
	output logic nBerrFsb,
	output logic nDinOE,
	output logic ioRdReq,
	output logic ioWrReq,
	input  logic ioAct,
	input  logic ioDone,
	input  logic ioBerr,
	output logic ale0,      // Level 0 closed when high
	output logic ioL0,
	output logic ioU0,
	output logic ale1       // Level 1 closed (occupied) when high
);

	xferStateT ts;
	logic ioActR;
	logic ioDoneR;
	logic sent;     // Current FSB cycle already handed over
	logic load1;    // Close level 1 next edge
	logic clear1;   // Reopen level 1 next edge
	logic ioRw1;    // Level 1 direction, high for read
	logic ioL1;
	logic ioU1;
	logic pwQueue;
	logic fsbReq;

	// One-flop input registers on the master's status
	always_ff @(posedge CLK) begin
		if (reset) begin
			ioActR <= 1'b0;
			ioDoneR <= 1'b0;
		end else begin
			ioActR <= ioAct;
			ioDoneR <= ioDone;
		end
	end

	// CPU read drivers on only for an I/O read outside the overlay
	assign nDinOE = !(!nAS && ioCs && nWE && !overlay);

	// Posted write arriving while the bridge is busy goes to level 1
	assign pwQueue = bact && !ale1 && !sent && ioPwCs && (ts != tsIdle);

	// New FSB request served directly from idle
	assign fsbReq = bact && ioCs && !ale1 && !sent;

	assign ioPwReady = !ale1;

	always_ff @(posedge CLK) begin
		if (reset) load1 <= 1'b0;
		else load1 <= pwQueue; // Address and strobes settle one cycle later
	end

	always_ff @(posedge CLK) begin
		if (pwQueue) ioRw1 <= nWE; // Direction taken right away
	end

	// Level 1 is emptied once its contents pass through tsStart
	always_ff @(posedge CLK) begin
		if (reset) clear1 <= 1'b0;
		else clear1 <= (ts == tsStart);
	end

	always_ff @(posedge CLK) begin
		if (reset) ale1 <= 1'b0;
		else if (load1) ale1 <= 1'b1; // Load wins over clear
		else if (clear1) ale1 <= 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (load1) begin
			ioL1 <= !nLDS;
			ioU1 <= !nUDS;
		end
	end

	// Transfer FSB, level 1 always served ahead of the FSB
	always_ff @(posedge CLK) begin
		if (reset) begin
			ts <= tsIdle;
			ioRdReq <= 1'b0;
			ioWrReq <= 1'b0;
			ale0 <= 1'b0;
		end else begin
			case (ts)
				tsIdle: begin
					if (ale1) begin
						ts <= tsStart;
						ioRdReq <= ioRw1;
						ioWrReq <= !ioRw1;
					end else if (fsbReq) begin
						ts <= tsStart;
						ioRdReq <= nWE;
						ioWrReq <= !nWE;
					end else begin
						ioRdReq <= 1'b0;
						ioWrReq <= 1'b0;
					end
					ale0 <= 1'b0;
				end
				tsStart: begin
					ts <= tsWaitAct; // Requests stay up
					ale0 <= 1'b1;    // Close level 0 on address and data
				end
				tsWaitAct: begin
					if (ioActR) begin
						ts <= tsWaitDone;
						ioRdReq <= 1'b0;
						ioWrReq <= 1'b0;
					end
					ale0 <= 1'b1;
				end
				tsWaitDone: begin
					if (!ioActR) ts <= tsIdle;
					ioRdReq <= 1'b0;
					ioWrReq <= 1'b0;
					ale0 <= 1'b0; // Master holds its own copy by now
				end
				default: ts <= tsIdle;
			endcase
		end
	end

	// Level 0 byte strobes, from level 1 or straight from the FSB
	always_ff @(posedge CLK) begin
		if (ts == tsIdle || ts == tsStart) begin
			if (ale1) begin
				ioL0 <= ioL1;
				ioU0 <= ioU1;
			end else if (ts == tsStart || fsbReq) begin
				ioL0 <= !nLDS;
				ioU0 <= !nUDS;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || !bact) sent <= 1'b0;
		else if (ioCs && !ale1 && (ioPwCs || ts == tsIdle)) sent <= 1'b1;
	end

	// Non-posted ready follows done, posted ready needs only room in level 1
	always_ff @(posedge CLK) begin
		if (reset || !bact) ioReady <= 1'b0;
		else if (sent && ioDoneR && nBerrFsb) ioReady <= 1'b1; // Not after a bus error
		else if (ioPwCs && !ale1) ioReady <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (reset || !bact) nBerrFsb <= 1'b1;
		else if (sent && ioBerr) nBerrFsb <= 1'b0;
	end

	// Only one direction is ever requested from the master
	assert property (@(posedge CLK) disable iff (reset) !(ioRdReq && ioWrReq))
		else $error("iobSlave: read and write requested together");

	// A second load never lands on an occupied level 1
	assert property (@(posedge CLK) disable iff (reset) ale1 |-> !load1)
		else $error("iobSlave: level 1 loaded while full");

endmodule

//--- iobLatch.sv
`timescale 1ns/1ps

module iobLatch import ioBridgePkg::*; (
	input  logic    CLK,
	input  logic    reset,
	input  fsbAddrT fsbAddr,
	input  ioDataT  fsbDataIn,
	input  logic    nUDS,
	input  logic    nLDS,
	input  logic    ale0,
	input  logic    ale1,
	input  logic    ioL0,
	input  logic    ioU0,
	input  logic    rdLoad,
	input  ioDataT  rdData,
	output fsbAddrT addr0,
	output ioDataT  data0,
	output byteEnT  be0,
	output ioDataT  fsbDataOut
);

	fsbAddrT addr1;
	ioDataT  data1;
	byteEnT  be1;

	// Level 1 follows the FSB while open
	always_ff @(posedge CLK) begin
		if (!ale1) begin
			addr1 <= fsbAddr;
			data1 <= fsbDataIn;
			be1 <= {!nUDS, !nLDS};
		end
	end

	// Level 0 follows level 1 when it holds a queued write, else the FSB
	always_ff @(posedge CLK) begin
		if (!ale0) begin
			addr0 <= ale1 ? addr1 : fsbAddr;
			data0 <= ale1 ? data1 : fsbDataIn;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) be0 <= '0;
		else if (!ale0) be0 <= {ioU0, ioL0}; // Slave already picked the source
	end

	// Read return word for the FSB
	always_ff @(posedge CLK) begin
		if (rdLoad) fsbDataOut <= rdData;
	end

	// Strobes the slave copied from level 1 match the lanes queued here
	assert property (@(posedge CLK) disable iff (reset)
		$rose(ale0) && $past(ale1) |-> be0 == $past(be1))
		else $error("iobLatch: level 0 byte enables differ from level 1");

endmodule

//--- iobMaster.sv
`timescale 1ns/1ps
`include "ioBridge_macros.svh"

module iobMaster import ioBridgePkg::*; (
	input  logic    CLK,
	input  logic    reset,
	input  logic    ioRdReq,
	input  logic    ioWrReq,
	input  fsbAddrT addr0,
	input  ioDataT  data0,
	input  byteEnT  be0,
	input  ioDataT  ioDataIn,   // Device read data
	input  logic    ioDevReady,
	input  logic    ioDevBerr,
	output logic    ioAct,
	output logic    ioDone,
	output logic    ioBerr,
	output logic    rdLoad,
	output ioDataT  rdData,
	output fsbAddrT ioAddr,
	output ioDataT  ioDataOut,
	output byteEnT  ioBe,
	output logic    ioRd,
	output logic    ioWr
);

	localparam int CntW = $clog2(`IOB_TIMEOUT + 1);

	iobStateT state;
	logic [CntW-1:0] cnt;   // Strobe cycles so far, zero in the setup beat
	logic isRead;
	logic failed;           // Device bus error or timeout
	logic setupBeat;
	logic strobeEnd;

	assign setupBeat = (state == mStrobe) && (cnt == '0);

	// Device answer counts only once the minimum width is met
	assign strobeEnd = ((cnt >= CntW'(`IOB_MIN_STROBE)) && (ioDevReady || ioDevBerr))
		|| (cnt == CntW'(`IOB_TIMEOUT));

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mIdle;
			cnt <= '0;
			ioAct <= 1'b0;
			ioDone <= 1'b0;
			ioBerr <= 1'b0;
			rdLoad <= 1'b0;
			ioRd <= 1'b0;
			ioWr <= 1'b0;
			ioBe <= '0;
			isRead <= 1'b0;
			failed <= 1'b0;
		end else begin
			case (state)
				mIdle: begin
					if (ioRdReq || ioWrReq) begin
						state <= mStrobe;
						ioAct <= 1'b1; // Held through the whole cycle
						cnt <= '0;
						isRead <= ioRdReq;
					end
				end
				mStrobe: begin
					if (setupBeat) begin
						// Level 0 is closed now, start the strobe
						ioRd <= isRead;
						ioWr <= !isRead;
						ioBe <= be0;
						cnt <= cnt + 1'b1;
					end else if (strobeEnd) begin
						ioRd <= 1'b0;
						ioWr <= 1'b0;
						ioBe <= '0;
						failed <= ioDevBerr || !ioDevReady; // Timeout is a bus error too
						state <= mFinish;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				mFinish: begin
					state <= mDone;
					ioAct <= 1'b0;
					ioDone <= 1'b1;
					ioBerr <= failed;
					rdLoad <= isRead && !failed; // Only good reads reach the FSB
				end
				mDone: begin
					state <= mIdle;
					ioDone <= 1'b0;
					ioBerr <= 1'b0;
					rdLoad <= 1'b0;
				end
				default: state <= mIdle;
			endcase
		end
	end

	// Own copy of address and data, level 0 reopens mid-cycle
	always_ff @(posedge CLK) begin
		if (setupBeat) begin
			ioAddr <= addr0;
			ioDataOut <= data0;
		end
		if (state == mStrobe && !setupBeat && strobeEnd) rdData <= ioDataIn;
	end

	assert property (@(posedge CLK) disable iff (reset) !(ioRd && ioWr))
		else $error("iobMaster: read and write strobes together");

	// Done is a single-cycle pulse
	assert property (@(posedge CLK) disable iff (reset) ioDone |=> !ioDone)
		else $error("iobMaster: ioDone longer than one cycle");

endmodule

//--- ioBridgeTop.sv
`timescale 1ns/1ps

module ioBridgeTop import ioBridgePkg::*; (
	input  logic    CLK,
	input  logic    reset,
	// FSB side
	input  fsbAddrT fsbAddr,
	input  ioDataT  fsbDataIn,
	input  logic    nAS,
	input  logic    nUDS,
	input  logic    nLDS,
	input  logic    nWE,
	input  logic    bact,
	input  logic    ioCs,
	input  logic    ioPwCs,
	input  logic    overlay,
	output ioDataT  fsbDataOut,
	output logic    nDinOE,
	output logic    ioReady,
	output logic    ioPwReady,
	output logic    nBerrFsb,
	// I/O side
	output fsbAddrT ioAddr,
	output ioDataT  ioDataOut,
	output byteEnT  ioBe,
	output logic    ioRd,
	output logic    ioWr,
	input  ioDataT  ioDataIn,
	input  logic    ioDevReady,
	input  logic    ioDevBerr
);

	logic ale0, ale1, ioL0, ioU0;  // Queue control from the slave
	logic ioRdReq, ioWrReq;
	logic ioAct, ioDone, ioBerr;   // Master status
	logic rdLoad;
	ioDataT rdData;
	fsbAddrT addr0;
	ioDataT data0;
	byteEnT be0;

	iobSlave slave (
		.CLK(CLK), .reset(reset),
		.nWE(nWE), .nAS(nAS), .nLDS(nLDS), .nUDS(nUDS),
		.bact(bact), .ioCs(ioCs), .ioPwCs(ioPwCs), .overlay(overlay),
		.ioReady(ioReady), .ioPwReady(ioPwReady), .nBerrFsb(nBerrFsb), .nDinOE(nDinOE),
		.ioRdReq(ioRdReq), .ioWrReq(ioWrReq),
		.ioAct(ioAct), .ioDone(ioDone), .ioBerr(ioBerr),
		.ale0(ale0), .ioL0(ioL0), .ioU0(ioU0), .ale1(ale1)
	);

	iobLatch latch (
		.CLK(CLK), .reset(reset),
		.fsbAddr(fsbAddr), .fsbDataIn(fsbDataIn), .nUDS(nUDS), .nLDS(nLDS),
		.ale0(ale0), .ale1(ale1), .ioL0(ioL0), .ioU0(ioU0),
		.rdLoad(rdLoad), .rdData(rdData),
		.addr0(addr0), .data0(data0), .be0(be0), .fsbDataOut(fsbDataOut)
	);

	iobMaster master (
		.CLK(CLK), .reset(reset),
		.ioRdReq(ioRdReq), .ioWrReq(ioWrReq),
		.addr0(addr0), .data0(data0), .be0(be0),
		.ioDataIn(ioDataIn), .ioDevReady(ioDevReady), .ioDevBerr(ioDevBerr),
		.ioAct(ioAct), .ioDone(ioDone), .ioBerr(ioBerr),
		.rdLoad(rdLoad), .rdData(rdData),
		.ioAddr(ioAddr), .ioDataOut(ioDataOut), .ioBe(ioBe), .ioRd(ioRd), .ioWr(ioWr)
	);

endmodule

//--- ioBridgeTb.sv
`timescale 1ns/1ps
`include "ioBridge_macros.svh"

module ioBridgeTb import ioBridgePkg::*; ();

	logic CLK = 1'b0;
	logic reset;
	fsbAddrT fsbAddr;
	ioDataT fsbDataIn;
	logic nAS, nUDS, nLDS, nWE, bact, ioCs, ioPwCs, overlay;
	ioDataT fsbDataOut;
	logic nDinOE, ioReady, ioPwReady, nBerrFsb;
	fsbAddrT ioAddr;
	ioDataT ioDataOut;
	byteEnT ioBe;
	logic ioRd, ioWr;
	ioDataT ioDataIn;
	logic ioDevReady, ioDevBerr;

	ioDataT shadow [0:255];   // What the FSB expects in each device word
	ioDataT devMem [0:255];   // Device contents
	fsbAddrT expAddrQ[$];     // Posted writes, in FSB order
	ioDataT expDataQ[$];
	byteEnT expBeQ[$];
	fsbAddrT seenAddrQ[$];    // Writes seen at the I/O port
	ioDataT seenDataQ[$];
	byteEnT seenBeQ[$];
	int valueErrors = 0;
	int otherErrors = 0;

	ioBridgeTop uut (
		.CLK(CLK), .reset(reset),
		.fsbAddr(fsbAddr), .fsbDataIn(fsbDataIn), .nAS(nAS), .nUDS(nUDS), .nLDS(nLDS),
		.nWE(nWE), .bact(bact), .ioCs(ioCs), .ioPwCs(ioPwCs), .overlay(overlay),
		.fsbDataOut(fsbDataOut), .nDinOE(nDinOE), .ioReady(ioReady),
		.ioPwReady(ioPwReady), .nBerrFsb(nBerrFsb),
		.ioAddr(ioAddr), .ioDataOut(ioDataOut), .ioBe(ioBe), .ioRd(ioRd), .ioWr(ioWr),
		.ioDataIn(ioDataIn), .ioDevReady(ioDevReady), .ioDevBerr(ioDevBerr)
	);

	always #20 CLK = ~CLK; // 40 ns period

	// Power-up contents, a function of the whole word index
	function automatic ioDataT fillWord(input int idx);
		return ioDataT'((idx * 40503) ^ 23130);
	endfunction

	function automatic ioDataT mergeBytes(input ioDataT old, input ioDataT nw, input byteEnT be);
		ioDataT res;
		res = old;
		if (be[1]) res[15:8] = nw[15:8]; // Upper lane
		if (be[0]) res[7:0] = nw[7:0];
		return res;
	endfunction

	// Expected word for a read of device word idx
	function automatic ioDataT refRead(input int idx);
		return shadow[idx];
	endfunction

	function automatic fsbAddrT wordAddr(input int idx);
		return `IOB_IO_BASE + fsbAddrT'(idx);
	endfunction

	function automatic logic faultingWord(input int idx);
		return idx >= 240; // Top 16 words answer with bus error
	endfunction

	task automatic checkData(input string name, input ioDataT exp, input ioDataT act);
		if (act !== exp) begin
			valueErrors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkAddr(input string name, input fsbAddrT exp, input fsbAddrT act);
		if (act !== exp) begin
			valueErrors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkBe(input string name, input byteEnT exp, input byteEnT act);
		if (act !== exp) begin
			valueErrors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			valueErrors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// One 68000 bus cycle into the I/O decode, ends on ioReady or bus error
	task automatic fsbCycle(input fsbAddrT addr, input logic write, input logic posted,
			input ioDataT wdata, input byteEnT be, output ioDataT rdata,
			output logic gotReady, output logic gotBerr, output logic oe, output int cycles);
		logic done;
		fsbAddr = addr;
		fsbDataIn = wdata;
		nWE = !write;
		nUDS = !be[1];
		nLDS = !be[0];
		nAS = 1'b0;
		bact = 1'b1;
		ioCs = 1'b1;
		ioPwCs = posted;
		done = 1'b0;
		cycles = 0;
		oe = 1'b1;
		gotReady = 1'b0;
		gotBerr = 1'b0;
		while (!done && cycles < 4 * (`IOB_TIMEOUT + 10)) begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles == 1) oe = nDinOE; // Read buffer enable early in the cycle
			gotReady = ioReady;
			gotBerr = !nBerrFsb;
			done = gotReady || gotBerr;
		end
		rdata = fsbDataOut;
		if (!done) begin
			otherErrors++;
			$display("FSB cycle at %h got neither ioReady nor a bus error", addr);
		end
		@(posedge CLK); // CPU keeps AS one more clock after DTACK
		#2;
		nAS = 1'b1;
		bact = 1'b0;
		nUDS = 1'b1;
		nLDS = 1'b1;
		nWE = 1'b1;
		ioCs = 1'b0;
		ioPwCs = 1'b0;
		@(posedge CLK);
		#2;
	endtask

	task automatic postWrite(input int idx, input ioDataT wd, input byteEnT be, output int cycles);
		ioDataT rd;
		logic rdy, berr, oe;
		fsbCycle(wordAddr(idx), 1'b1, 1'b1, wd, be, rd, rdy, berr, oe, cycles);
		checkFlag($sformatf("posted write %0d bus error", idx), 1'b0, berr);
		if (rdy) begin
			shadow[idx] = mergeBytes(shadow[idx], wd, be);
			expAddrQ.push_back(wordAddr(idx));
			expDataQ.push_back(wd);
			expBeQ.push_back(be);
		end
	endtask

	task automatic readCheck(input string name, input int idx, input logic ovl);
		ioDataT rd;
		logic rdy, berr, oe;
		int cycles;
		overlay = ovl;
		fsbCycle(wordAddr(idx), 1'b0, 1'b0, '0, 2'b11, rd, rdy, berr, oe, cycles);
		overlay = 1'b0;
		checkFlag({name, " bus error"}, 1'b0, berr);
		checkData($sformatf("%s word %0d", name, idx), refRead(idx), rd);
		checkFlag({name, " nDinOE"}, ovl, oe);
	endtask

	task automatic errRead(input string name, input fsbAddrT addr);
		ioDataT rd;
		logic rdy, berr, oe;
		int cycles;
		fsbCycle(addr, 1'b0, 1'b0, '0, 2'b11, rd, rdy, berr, oe, cycles);
		checkFlag({name, " bus error"}, 1'b1, berr);
		checkFlag({name, " ioReady"}, 1'b0, rdy);
		checkFlag({name, " bus error latency"}, 1'b1, cycles <= `IOB_TIMEOUT + 10);
	endtask

	// Writes at the I/O port against posted writes, in order
	task automatic drainCompare(input string name);
		int guard;
		int n;
		guard = 0;
		while (seenAddrQ.size() < expAddrQ.size() && guard < 4 * (`IOB_TIMEOUT + 10)) begin
			@(posedge CLK);
			#2;
			guard++;
		end
		if (seenAddrQ.size() != expAddrQ.size()) begin
			otherErrors++;
			$display("%s: %0d writes posted but %0d seen at the I/O port", name,
				expAddrQ.size(), seenAddrQ.size());
		end
		n = seenAddrQ.size() < expAddrQ.size() ? seenAddrQ.size() : expAddrQ.size();
		for (int i = 0; i < n; i++) begin
			checkAddr($sformatf("%s write %0d address", name, i), expAddrQ[i], seenAddrQ[i]);
			checkData($sformatf("%s write %0d data", name, i), expDataQ[i], seenDataQ[i]);
			checkBe($sformatf("%s write %0d lanes", name, i), expBeQ[i], seenBeQ[i]);
		end
		expAddrQ.delete();
		expDataQ.delete();
		expBeQ.delete();
		seenAddrQ.delete();
		seenDataQ.delete();
		seenBeQ.delete();
	endtask

	// Slow device, answers words inside the I/O window only
	initial begin : deviceModel
		int off;
		int delay;
		int guard;
		ioDevReady = 1'b0;
		ioDevBerr = 1'b0;
		ioDataIn = '0;
		for (int i = 0; i < 256; i++) devMem[i] = fillWord(i);
		forever begin
			@(posedge CLK);
			#2;
			if (ioRd || ioWr) begin
				off = int'(ioAddr) - int'(`IOB_IO_BASE);
				if (off >= 0 && off < `IOB_IO_WORDS) begin
					delay = $urandom_range(1, 10);
					repeat (delay) @(posedge CLK);
					#2;
					if (faultingWord(off)) ioDevBerr = 1'b1;
					else begin
						if (ioWr) devMem[off] = mergeBytes(devMem[off], ioDataOut, ioBe);
						ioDataIn = devMem[off];
						ioDevReady = 1'b1;
					end
				end
				guard = 0; // Answer held until the strobe drops
				while ((ioRd || ioWr) && guard < `IOB_TIMEOUT + 10) begin
					@(posedge CLK);
					#2;
					guard++;
				end
				if (ioRd || ioWr) begin
					otherErrors++;
					$display("I/O strobe at %h never dropped", ioAddr);
				end
				ioDevReady = 1'b0;
				ioDevBerr = 1'b0;
			end
		end
	end

	initial begin : writeMonitor
		logic wrLast;
		wrLast = 1'b0;
		forever begin
			@(posedge CLK);
			#1;
			if (ioWr && !wrLast) begin // New write strobe
				seenAddrQ.push_back(ioAddr);
				seenDataQ.push_back(ioDataOut);
				seenBeQ.push_back(ioBe);
			end
			wrLast = ioWr;
		end
	end

	initial begin : mainFlow
		int cycles;
		int idx;
		void'($urandom(32'h1062));
		reset = 1'b1;
		fsbAddr = '0;
		fsbDataIn = '0;
		nAS = 1'b1;
		nUDS = 1'b1;
		nLDS = 1'b1;
		nWE = 1'b1;
		bact = 1'b0;
		ioCs = 1'b0;
		ioPwCs = 1'b0;
		overlay = 1'b0;
		for (int i = 0; i < 256; i++) shadow[i] = fillWord(i);
		repeat (16) @(posedge CLK);
		#2;
		reset = 1'b0;

		// Idle bus after reset
		checkFlag("reset ioRd", 1'b0, ioRd);
		checkFlag("reset ioWr", 1'b0, ioWr);
		checkFlag("reset ioReady", 1'b0, ioReady);
		checkBe("reset ioBe", 2'b00, ioBe);
		checkFlag("reset nBerrFsb", 1'b1, nBerrFsb);
		checkFlag("reset ioPwReady", 1'b1, ioPwReady);

		// Back-to-back posted writes, the third one waits for level 1
		postWrite(3, 16'hBEEF, 2'b11, cycles);
		checkFlag("first posted ready latency", 1'b1, cycles <= 2);
		postWrite(4, 16'h1234, 2'b10, cycles);
		checkFlag("second posted ready latency", 1'b1, cycles <= 2);
		checkFlag("queued write ioPwReady", 1'b0, ioPwReady);
		postWrite(5, 16'hA55A, 2'b01, cycles);
		checkFlag("blocked posted write waits", 1'b1, cycles > 2);
		drainCompare("back-to-back writes");

		// Reads after byte-masked writes
		for (int i = 0; i < 8; i++) begin
			idx = $urandom_range(0, 239);
			postWrite(idx, ioDataT'($urandom), byteEnT'($urandom_range(1, 3)), cycles);
			readCheck("read after write", idx, 1'b0);
			readCheck("random read", $urandom_range(0, 239), 1'b0);
		end
		readCheck("overlay read", 7, 1'b1);
		drainCompare("masked writes");

		// Bus errors
		errRead("unmapped read", `IOB_IO_BASE + 23'h1000);
		errRead("faulting read", wordAddr(245));

		// Random traffic against the shadow model
		for (int i = 0; i < 200; i++) begin
			idx = $urandom_range(0, 239);
			if ($urandom_range(0, 1) == 1)
				postWrite(idx, ioDataT'($urandom), byteEnT'($urandom_range(1, 3)), cycles);
			else
				readCheck("mixed read", idx, 1'b0);
		end
		drainCompare("mixed writes");

		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
ioBridgePkg.sv
iobSlave.sv
iobLatch.sv
iobMaster.sv
ioBridgeTop.sv
ioBridgeTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ioBridgeTb
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASSMSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
